/* common/isa_pkg.sv */
// instruction set encodings, field layouts and decoded fields for the 16-bit processor
`default_nettype none

package isa_pkg;

	localparam int word_w = 16;
	localparam int addr_w = 9; // 512-word memory
	localparam int reg_count = 8;
	localparam int reg_idx_w = $clog2(reg_count);

	typedef logic [2:0] opcode_t;
	typedef logic [1:0] op_t;
	typedef logic [1:0] shift_t;

	localparam opcode_t opc_mov = 3'b110;
	localparam opcode_t opc_alu = 3'b101;
	localparam opcode_t opc_ldr = 3'b011;
	localparam opcode_t opc_str = 3'b100;
	localparam opcode_t opc_halt = 3'b111;

	localparam op_t op_movi = 2'b10;
	localparam op_t op_movs = 2'b00;
	localparam op_t op_add = 2'b00;
	localparam op_t op_and = 2'b10;
	localparam op_t op_mvn = 2'b11;
	localparam op_t op_mem = 2'b00; // LDR and STR

	localparam shift_t sh_none = 2'b00;
	localparam shift_t sh_lsl = 2'b01; // left by one
	localparam shift_t sh_lsr = 2'b10; // logical right by one
	localparam shift_t sh_asr = 2'b11; // arithmetic right by one

	// the ALU is steered straight from the op field
	localparam op_t alu_add = 2'b00;
	localparam op_t alu_and = 2'b10;
	localparam op_t alu_not_b = 2'b11;

	typedef struct packed {
		opcode_t opcode;
		op_t op;
		logic [reg_idx_w-1:0] rn;
		logic [reg_idx_w-1:0] rd;
		shift_t shift;
		logic [reg_idx_w-1:0] rm; // also the low bits of imm5
	} rr_fmt_t;

	typedef struct packed {
		opcode_t opcode;
		op_t op;
		logic [reg_idx_w-1:0] rn;
		logic [7:0] imm8;
	} imm_fmt_t;

	typedef union packed {
		rr_fmt_t rr;
		imm_fmt_t imm;
	} instr_u;

	typedef struct packed {
		opcode_t opcode;
		op_t op;
		shift_t shift;
		logic [word_w-1:0] sximm5;
		logic [word_w-1:0] sximm8;
	} dec_t;

endpackage

`default_nettype wire

/* common/ctrl_pkg.sv */
// controller state codes, memory commands and the control bundles driven by the FSM
`default_nettype none

package ctrl_pkg;

	localparam int mem_cmd_w = 2;
	localparam logic [mem_cmd_w-1:0] mcmd_none = 2'b00;
	localparam logic [mem_cmd_w-1:0] mcmd_read = 2'b01;
	localparam logic [mem_cmd_w-1:0] mcmd_write = 2'b10;

	// steps of one sequence are numbered in order, the FSM counts through them
	localparam int state_w = 5;
	localparam logic [state_w-1:0] st_reset = 5'd0;
	localparam logic [state_w-1:0] st_if1 = 5'd1;
	localparam logic [state_w-1:0] st_if2 = 5'd2;
	localparam logic [state_w-1:0] st_update_pc = 5'd3;
	localparam logic [state_w-1:0] st_movi = 5'd4;
	localparam logic [state_w-1:0] st_movs1 = 5'd5; // MOV shift and MVN
	localparam logic [state_w-1:0] st_movs2 = 5'd6;
	localparam logic [state_w-1:0] st_movs3 = 5'd7;
	localparam logic [state_w-1:0] st_alu1 = 5'd8; // ADD and AND
	localparam logic [state_w-1:0] st_alu2 = 5'd9;
	localparam logic [state_w-1:0] st_alu3 = 5'd10;
	localparam logic [state_w-1:0] st_alu4 = 5'd11;
	localparam logic [state_w-1:0] st_ldr1 = 5'd12;
	localparam logic [state_w-1:0] st_ldr2 = 5'd13;
	localparam logic [state_w-1:0] st_ldr3 = 5'd14;
	localparam logic [state_w-1:0] st_ldr4 = 5'd15;
	localparam logic [state_w-1:0] st_ldr5 = 5'd16;
	localparam logic [state_w-1:0] st_str1 = 5'd17;
	localparam logic [state_w-1:0] st_str2 = 5'd18;
	localparam logic [state_w-1:0] st_str3 = 5'd19;
	localparam logic [state_w-1:0] st_str4 = 5'd20;
	localparam logic [state_w-1:0] st_str5 = 5'd21;
	localparam logic [state_w-1:0] st_halt = 5'd22;

	localparam int nsel_w = 3;
	localparam logic [nsel_w-1:0] nsel_rn = 3'b001;
	localparam logic [nsel_w-1:0] nsel_rd = 3'b010;
	localparam logic [nsel_w-1:0] nsel_rm = 3'b100;

	localparam int vsel_w = 2;
	localparam logic [vsel_w-1:0] vsel_alu = 2'b00; // C register
	localparam logic [vsel_w-1:0] vsel_imm = 2'b01; // sximm8
	localparam logic [vsel_w-1:0] vsel_mem = 2'b10; // read_data

	typedef struct packed {
		logic [nsel_w-1:0] nsel;
		logic [vsel_w-1:0] vsel;
		logic write;
		logic load_a;
		logic load_b;
		logic load_c;
		logic asel; // zero the A operand
		logic bsel; // sximm5 as the B operand
	} dp_ctrl_t;

	typedef struct packed {
		logic [mem_cmd_w-1:0] cmd;
		logic addr_sel; // 1 puts the PC on the address bus
		logic load_ir;
		logic load_pc;
		logic reset_pc;
		logic load_addr;
	} mem_ctrl_t;

endpackage

`default_nettype wire

/* datapath/regfile.sv */
// register file of eight 16-bit words sharing one index for write and read
`default_nettype none

module regfile (
	input wire clk,
	input wire write,
	input wire [2:0] num,
	input wire [15:0] wdata,
	output logic [15:0] rdata
);
	logic [15:0] regs [8];

	always_ff @(posedge clk) begin
		if (write)
			regs[num] <= wdata;
	end

	assign rdata = regs[num]; // asynchronous read

endmodule

`default_nettype wire

/* datapath/datapath.sv */
// datapath with operand registers, shifter, ALU and writeback select around the register file
`default_nettype none

module datapath (
	input wire clk,
	input wire ctrl_pkg::dp_ctrl_t ctrl,
	input wire isa_pkg::dec_t dec,
	input wire [isa_pkg::reg_idx_w-1:0] reg_num,
	input wire [isa_pkg::word_w-1:0] mdata,
	output logic [isa_pkg::word_w-1:0] result
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [word_w-1:0] rdata;
	logic [word_w-1:0] wdata;
	logic [word_w-1:0] a_reg;
	logic [word_w-1:0] b_reg;
	logic [word_w-1:0] b_shift;
	logic [word_w-1:0] a_op;
	logic [word_w-1:0] b_op;
	logic [word_w-1:0] alu_out;

	regfile regs (
		.clk (clk),
		.write (ctrl.write),
		.num (reg_num),
		.wdata (wdata),
		.rdata (rdata)
	);

	always_comb begin
		case (ctrl.vsel)
			vsel_alu: wdata = result;
			vsel_imm: wdata = dec.sximm8;
			vsel_mem: wdata = mdata;
			default: wdata = '0;
		endcase
	end

	always_comb begin
		case (dec.shift)
			sh_lsl: b_shift = {b_reg[word_w-2:0], 1'b0};
			sh_lsr: b_shift = {1'b0, b_reg[word_w-1:1]};
			sh_asr: b_shift = {b_reg[word_w-1], b_reg[word_w-1:1]};
			default: b_shift = b_reg;
		endcase
	end

	assign a_op = ctrl.asel ? '0 : a_reg;
	assign b_op = ctrl.bsel ? dec.sximm5 : b_shift; // immediate bypasses the shifter

	always_comb begin
		case (dec.op)
			alu_add: alu_out = a_op + b_op;
			alu_and: alu_out = a_op & b_op;
			alu_not_b: alu_out = ~b_op;
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_a)
			a_reg <= rdata;
		if (ctrl.load_b)
			b_reg <= rdata;
		if (ctrl.load_c)
			result <= alu_out; // C register
	end

endmodule

`default_nettype wire

/* hdl/mem_access.sv */
// memory-side registers holding the PC, instruction and data address, plus the address mux
`default_nettype none

module mem_access (
	input wire clk,
	input wire ctrl_pkg::mem_ctrl_t mem_ctrl,
	input wire [isa_pkg::word_w-1:0] read_data,
	input wire [isa_pkg::word_w-1:0] result,
	output isa_pkg::instr_u instr,
	output logic [isa_pkg::addr_w-1:0] mem_addr
);
	import isa_pkg::*;

	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] data_addr;

	always_ff @(posedge clk) begin
		if (mem_ctrl.load_pc)
			pc <= mem_ctrl.reset_pc ? '0 : pc + 1'b1; // restart or step to the next word
		if (mem_ctrl.load_ir)
			instr <= read_data; // word from the read issued in IF1
		if (mem_ctrl.load_addr)
			data_addr <= result[addr_w-1:0];
	end

	assign mem_addr = mem_ctrl.addr_sel ? pc : data_addr;

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
// instruction decoder that splits fields, picks the register index and sign-extends immediates
`default_nettype none

module instr_decoder (
	input wire isa_pkg::instr_u instr,
	input wire [ctrl_pkg::nsel_w-1:0] nsel,
	output isa_pkg::dec_t dec,
	output logic [isa_pkg::reg_idx_w-1:0] reg_num
);
	import isa_pkg::*;

	always_comb begin
		dec.opcode = instr.rr.opcode;
		dec.op = instr.rr.op;
		// LDR and STR keep imm5 in the shift bits so the shifter must pass B unchanged
		if (instr.rr.opcode == opc_ldr || instr.rr.opcode == opc_str) begin
			dec.shift = sh_none;
		end else begin
			dec.shift = instr.rr.shift;
		end
		dec.sximm5 = {{(word_w - 5){instr.rr.shift[1]}}, instr.rr.shift, instr.rr.rm};
		dec.sximm8 = {{(word_w - 8){instr.imm.imm8[7]}}, instr.imm.imm8};
	end

	// one-hot choice between the three register fields
	assign reg_num = ({reg_idx_w{nsel[0]}} & instr.rr.rn)
		| ({reg_idx_w{nsel[1]}} & instr.rr.rd)
		| ({reg_idx_w{nsel[2]}} & instr.rr.rm);

endmodule

`default_nettype wire

/* hdl/controller.sv */
// multicycle FSM that sequences fetch, dispatch and the execute steps of each instruction
`default_nettype none

module controller (
	input wire clk,
	input wire reset,
	input wire isa_pkg::opcode_t opcode,
	input wire isa_pkg::op_t op,
	output ctrl_pkg::dp_ctrl_t dp_ctrl,
	output ctrl_pkg::mem_ctrl_t mem_ctrl
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [state_w-1:0] state;
	logic [state_w-1:0] next_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			st_update_pc: begin
				case (opcode)
					opc_mov: begin
						case (op)
							op_movi: next_state = st_movi;
							op_movs: next_state = st_movs1;
							default: next_state = st_halt;
						endcase
					end
					opc_alu: begin
						case (op)
							op_add, op_and: next_state = st_alu1;
							op_mvn: next_state = st_movs1; // same steps as MOV shift
							default: next_state = st_halt; // CMP is not implemented
						endcase
					end
					opc_ldr: next_state = (op == op_mem) ? st_ldr1 : st_halt;
					opc_str: next_state = (op == op_mem) ? st_str1 : st_halt;
					opc_halt: next_state = st_halt;
					default: next_state = st_halt;
				endcase
			end
			st_movi, st_movs3, st_alu4, st_ldr5, st_str5: next_state = st_if1;
			st_halt: next_state = st_halt; // held until reset
			default: next_state = state + 1'b1; // next step of the sequence
		endcase
	end

	always_comb begin
		dp_ctrl = '0;
		mem_ctrl = '0;
		case (state)
			st_reset: begin
				mem_ctrl.load_pc = 1'b1;
				mem_ctrl.reset_pc = 1'b1;
			end
			st_if1: begin
				mem_ctrl.cmd = mcmd_read;
				mem_ctrl.addr_sel = 1'b1;
			end
			st_if2: begin
				mem_ctrl.cmd = mcmd_read;
				mem_ctrl.addr_sel = 1'b1;
				mem_ctrl.load_ir = 1'b1;
			end
			st_update_pc: mem_ctrl.load_pc = 1'b1;
			st_movi: begin
				dp_ctrl.nsel = nsel_rn;
				dp_ctrl.vsel = vsel_imm;
				dp_ctrl.write = 1'b1;
			end
			st_alu1, st_ldr1, st_str1: begin
				dp_ctrl.nsel = nsel_rn;
				dp_ctrl.load_a = 1'b1;
			end
			st_movs1, st_alu2: begin
				dp_ctrl.nsel = nsel_rm;
				dp_ctrl.load_b = 1'b1;
			end
			st_movs2, st_str4: begin
				dp_ctrl.asel = 1'b1; // C = 0 op shifted B
				dp_ctrl.load_c = 1'b1;
			end
			st_alu3: dp_ctrl.load_c = 1'b1;
			st_ldr2, st_str2: begin
				dp_ctrl.bsel = 1'b1; // base plus sximm5
				dp_ctrl.load_c = 1'b1;
			end
			st_movs3, st_alu4: begin
				dp_ctrl.nsel = nsel_rd;
				dp_ctrl.vsel = vsel_alu;
				dp_ctrl.write = 1'b1;
			end
			st_ldr3: mem_ctrl.load_addr = 1'b1;
			st_ldr4: mem_ctrl.cmd = mcmd_read;
			st_ldr5: begin
				mem_ctrl.cmd = mcmd_read; // data from the ldr4 read lands now
				dp_ctrl.nsel = nsel_rd;
				dp_ctrl.vsel = vsel_mem;
				dp_ctrl.write = 1'b1;
			end
			st_str3: begin
				mem_ctrl.load_addr = 1'b1;
				dp_ctrl.nsel = nsel_rd;
				dp_ctrl.load_b = 1'b1;
			end
			st_str5: mem_ctrl.cmd = mcmd_write;
			default: ; // halt keeps everything idle
		endcase
	end

endmodule

`default_nettype wire

/* hdl/cpu.sv */
// processor top level joining the controller, decoder, memory-side registers and datapath
`default_nettype none

module cpu (
	input wire clk,
	input wire reset,
	input wire [isa_pkg::word_w-1:0] read_data,
	output logic [ctrl_pkg::mem_cmd_w-1:0] mem_cmd,
	output logic [isa_pkg::addr_w-1:0] mem_addr,
	output logic [isa_pkg::word_w-1:0] write_data
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	dp_ctrl_t dp_ctrl;
	mem_ctrl_t mem_ctrl;
	instr_u instr;
	dec_t dec;
	logic [reg_idx_w-1:0] reg_num;

	assign mem_cmd = mem_ctrl.cmd;

	controller fsm (
		.clk (clk),
		.reset (reset),
		.opcode (dec.opcode),
		.op (dec.op),
		.dp_ctrl (dp_ctrl),
		.mem_ctrl (mem_ctrl)
	);

	mem_access mem_side (
		.clk (clk),
		.mem_ctrl (mem_ctrl),
		.read_data (read_data),
		.result (write_data), // C register doubles as the data address source
		.instr (instr),
		.mem_addr (mem_addr)
	);

	instr_decoder decoder (
		.instr (instr),
		.nsel (dp_ctrl.nsel),
		.dec (dec),
		.reg_num (reg_num)
	);

	datapath dp (
		.clk (clk),
		.ctrl (dp_ctrl),
		.dec (dec),
		.reg_num (reg_num),
		.mdata (read_data),
		.result (write_data)
	);

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
// testbench clock source with a power-on reset held for ten cycles
`default_nettype none

module tb_clock (
	output logic clk,
	output logic por
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // period of 10
	end

	initial begin
		por <= 1'b1;
		#1;
		repeat (10) @(negedge clk);
		por <= 1'b0; // released on a falling edge
	end

endmodule

`default_nettype wire

/* verif/tb_checker.sv */
// ISA reference model and bus monitor that checks every memory access of the processor
`default_nettype none

module tb_checker (
	input logic clk,
	input logic reset,
	input logic [1:0] mem_cmd,
	input logic [8:0] mem_addr,
	input logic [15:0] write_data,
	input logic [15:0] image [512],
	input logic end_run,
	input logic summary,
	input int tb_errors,
	output logic done,
	output int errors
);
	logic [15:0] regs [8];
	logic [15:0] model_mem [512];
	logic exp_write [$];
	logic [8:0] exp_addr [$];
	logic [15:0] exp_data [$];
	int idx = 0;
	int stores = 0;
	int writes = 0;
	int total_writes = 0;
	int checks = 0;
	int err_count = 0;
	logic built = 1'b0;
	logic was_reset = 1'b0;
	logic [1:0] prev_cmd = 2'b00;
	logic [8:0] prev_addr = '0;

	assign errors = err_count;

	task automatic compare(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			err_count++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [15:0] shifted(input logic [15:0] v, input logic [1:0] sh);
		case (sh)
			2'b01: return {v[14:0], 1'b0};
			2'b10: return {1'b0, v[15:1]};
			2'b11: return {v[15], v[15:1]};
			default: return v;
		endcase
	endfunction

	task automatic expect_access(input logic wr, input logic [8:0] addr, input logic [15:0] data);
		exp_write.push_back(wr);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// runs the program image to its end and lists every access it must make
	task automatic run_model();
		logic [15:0] ir;
		logic [15:0] b;
		logic [8:0] pc;
		logic [8:0] addr;
		logic halted;
		pc = '0;
		halted = 1'b0;
		stores = 0;
		exp_write.delete();
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 512; i++)
			model_mem[i] = image[i];
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int n = 0; n < 1000 && !halted; n++) begin
			expect_access(1'b0, pc, '0); // fetch
			ir = model_mem[pc];
			pc = pc + 9'd1;
			b = shifted(regs[ir[2:0]], ir[4:3]);
			addr = 9'(regs[ir[10:8]] + {{11{ir[4]}}, ir[4:0]});
			case (ir[15:11])
				5'b110_10: regs[ir[10:8]] = {{8{ir[7]}}, ir[7:0]};
				5'b110_00: regs[ir[7:5]] = b;
				5'b101_00: regs[ir[7:5]] = regs[ir[10:8]] + b;
				5'b101_10: regs[ir[7:5]] = regs[ir[10:8]] & b;
				5'b101_11: regs[ir[7:5]] = ~b;
				5'b011_00: begin
					expect_access(1'b0, addr, '0);
					regs[ir[7:5]] = model_mem[addr];
				end
				5'b100_00: begin
					expect_access(1'b1, addr, regs[ir[7:5]]);
					model_mem[addr] = regs[ir[7:5]];
					stores++;
				end
				default: halted = 1'b1; // halt, CMP and undefined words
			endcase
		end
		idx = 0;
		built = 1'b1;
	endtask

	task automatic check_access();
		if (idx >= exp_addr.size()) begin
			err_count++;
			$display("memory access at address %h after the program should have stopped",
				mem_addr);
			return;
		end
		compare("access_cmd", 16'(exp_write[idx] ? 2'b10 : 2'b01), 16'(mem_cmd));
		compare(exp_write[idx] ? "store_addr" : "read_addr", 16'(exp_addr[idx]),
			16'(mem_addr));
		if (exp_write[idx])
			compare("store_data", exp_data[idx], write_data);
		idx++;
	endtask

	always @(negedge clk) begin
		if (reset) begin
			compare("reset_cmd", 16'h0000, 16'(mem_cmd));
			was_reset = 1'b1;
			built = 1'b0;
			prev_cmd = 2'b00;
			done <= 1'b0;
		end else begin
			if (was_reset) begin
				run_model(); // image is final by the time reset drops
				was_reset = 1'b0;
				writes = 0;
			end
			// a new access starts when the command or the address changes
			if (mem_cmd != 2'b00 && (mem_cmd != prev_cmd || mem_addr != prev_addr)) begin
				if (mem_cmd == 2'b10) begin
					writes++;
					total_writes++;
				end
				check_access();
			end
			prev_cmd = mem_cmd;
			prev_addr = mem_addr;
			done <= built && idx == exp_addr.size();
		end
		if (end_run)
			compare("store_count", 16'(stores), 16'(writes));
		if (summary)
			$display("checks: %0d, errors: %0d, testbench errors: %0d, stores seen: %0d",
				checks, err_count, tb_errors, total_writes);
	end

endmodule

`default_nettype wire

/* verif/tb_top.sv */
// testbench top with clock, reset, memory model, program generator and the processor
`default_nettype none

module tb_top;
	logic clk;
	logic por;
	logic restart;
	logic reset;
	logic [1:0] mem_cmd;
	logic [8:0] mem_addr;
	logic [15:0] write_data;
	logic [15:0] read_data = '0;
	logic [15:0] mem [512];
	logic [15:0] image [512];
	logic rd_pending = 1'b0;
	logic [8:0] rd_addr = '0;
	logic end_run;
	logic summary;
	logic done;
	int errors;
	int tb_errors;
	logic [31:0] seed;

	tb_clock clock_gen (
		.clk (clk),
		.por (por)
	);

	assign reset = por | restart;

	cpu DUT (
		.clk (clk),
		.reset (reset),
		.read_data (read_data),
		.mem_cmd (mem_cmd),
		.mem_addr (mem_addr),
		.write_data (write_data)
	);

	tb_checker chk (
		.clk (clk),
		.reset (reset),
		.mem_cmd (mem_cmd),
		.mem_addr (mem_addr),
		.write_data (write_data),
		.image (image),
		.end_run (end_run),
		.summary (summary),
		.tb_errors (tb_errors),
		.done (done),
		.errors (errors)
	);

	// 512-word memory, read data shows up one edge after the read command
	always @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < 512; i++)
				mem[i] <= image[i]; // program loads while reset is held
			rd_pending <= 1'b0;
		end else begin
			if (rd_pending)
				read_data <= mem[rd_addr];
			rd_pending <= (mem_cmd == 2'b01);
			rd_addr <= mem_addr;
			if (mem_cmd == 2'b10)
				mem[mem_addr] <= write_data;
		end
	end

	function automatic logic [31:0] pick(input logic [31:0] n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	function automatic logic [15:0] mov_imm_word(input logic [31:0] rn, input logic [31:0] imm);
		return {3'b110, 2'b10, rn[2:0], imm[7:0]};
	endfunction

	function automatic logic [15:0] reg_form_word(input logic [2:0] opc, input logic [1:0] op,
		input logic [31:0] rn, input logic [31:0] rd, input logic [31:0] sh,
		input logic [31:0] rm);
		return {opc, op, rn[2:0], rd[2:0], sh[1:0], rm[2:0]};
	endfunction

	function automatic logic [15:0] mem_form_word(input logic [2:0] opc, input logic [31:0] rn,
		input logic [31:0] rd, input logic [31:0] imm5);
		return {opc, 2'b00, rn[2:0], rd[2:0], imm5[4:0]};
	endfunction

	// random program, each result register is stored right after it is written
	task automatic build_program(input int items, input logic [15:0] last);
		logic [31:0] kind;
		logic [31:0] rd;
		logic [31:0] r;
		int pc;
		for (int i = 0; i < 6; i++)
			image[i] = mov_imm_word(i, pick(256));
		image[6] = mov_imm_word(6, 128 + pick(65)); // bases -128 to -64
		image[7] = mov_imm_word(7, 128 + pick(65));
		pc = 8;
		for (int k = 0; k < items; k++) begin
			kind = pick(7);
			rd = pick(6);
			case (kind)
				0: image[pc] = mov_imm_word(rd, pick(256));
				1: image[pc] = reg_form_word(3'b110, 2'b00, pick(8), rd, pick(4), pick(8));
				2: image[pc] = reg_form_word(3'b101, 2'b00, pick(8), rd, pick(4), pick(8));
				3: image[pc] = reg_form_word(3'b101, 2'b10, pick(8), rd, pick(4), pick(8));
				4: image[pc] = reg_form_word(3'b101, 2'b11, pick(8), rd, pick(4), pick(8));
				5: image[pc] = mem_form_word(3'b011, 6 + pick(2), rd, pick(16));
				default: image[pc] = mem_form_word(3'b100, 6 + pick(2), pick(8), pick(16));
			endcase
			pc++;
			if (kind != 6) begin
				image[pc] = mem_form_word(3'b100, 6 + pick(2), rd, pick(16));
				pc++;
			end
		end
		image[pc] = last;
		image[pc + 1] = mem_form_word(3'b100, 6, 0, 0); // must never execute
		for (int a = pc + 2; a < 368; a++)
			image[a] = 16'he000 | 16'(a);
		for (int a = 368; a < 512; a++) begin
			r = $random(seed);
			image[a] = r[15:0];
		end
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		restart <= 1'b1;
		repeat (3) @(negedge clk);
		restart <= 1'b0;
	endtask

	task automatic wait_done(input string name);
		int n;
		for (n = 0; n < 5000 && done !== 1'b1; n++)
			@(negedge clk);
		if (done !== 1'b1) begin
			tb_errors++;
			$display("timeout: the %s did not finish within 5000 cycles", name);
		end
	endtask

	task automatic quiet_and_close();
		repeat (50) @(negedge clk); // checker flags any access here
		end_run <= 1'b1;
		@(negedge clk);
		end_run <= 1'b0;
	endtask

	initial begin
		restart <= 1'b0;
		end_run <= 1'b0;
		summary <= 1'b0;
		tb_errors = 0;
		seed = 32'hcdab1b40;
		build_program(60, 16'he000); // ends in HALT
		wait_done("first program");
		quiet_and_close();
		build_program(60, 16'he000);
		pulse_reset();
		repeat (150) @(negedge clk); // let it run partway
		build_program(20, 16'ha801); // ends in CMP r0, r1
		pulse_reset();
		wait_done("CMP program");
		quiet_and_close();
		summary <= 1'b1;
		@(negedge clk);
		summary <= 1'b0;
		@(posedge clk);
		if (errors == 0 && tb_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
common/isa_pkg.sv
common/ctrl_pkg.sv
datapath/regfile.sv
datapath/datapath.sv
hdl/mem_access.sv
hdl/instr_decoder.sv
hdl/controller.sv
hdl/cpu.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top
FILELIST = all.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
